/* common/conv_params.svh */
`ifndef CONV_PARAMS_SVH
`define CONV_PARAMS_SVH

// Datapath widths
`define CONV_DATA_W 8
`define CONV_ACC_W 20
`define CONV_OUT_W 16

// Layer shape
`define CONV_CH_IN 4
`define CONV_CH_OUT 3

// Output alignment FIFO
`define CONV_FIFO_DEPTH 8
// Occupancy that starts streaming
`define CONV_OUT_START 4

`endif

/* common/conv_pkg.sv */
`include "conv_params.svh"

package conv_pkg;

  ////////////////////////////////////////////////////////////
  // Data words
  ////////////////////////////////////////////////////////////
  typedef logic signed [`CONV_DATA_W-1:0] pixel_t;
  typedef logic signed [`CONV_DATA_W-1:0] weight_t;
  typedef logic signed [`CONV_ACC_W-1:0] acc_t;
  typedef logic signed [`CONV_OUT_W-1:0] out_t;

  // Channel indices
  typedef logic [$clog2(`CONV_CH_IN)-1:0] ic_idx_t;
  typedef logic [$clog2(`CONV_CH_OUT)-1:0] oc_idx_t;

  ////////////////////////////////////////////////////////////
  // Control encodings
  ////////////////////////////////////////////////////////////
  // Role of a beat inside one output channel's sum
  typedef enum logic [1:0] {
    MAC_FIRST,
    MAC_ACC,
    MAC_LAST
  } mac_op_t;

  typedef enum logic {
    RP_FILL,
    RP_PLAY
  } replay_state_t;

  // One replayed channel value with its position
  typedef struct packed {
    pixel_t  data;
    ic_idx_t ic;
    oc_idx_t oc;
    mac_op_t op;
  } replay_beat_t;

endpackage

/* conv1x1/conv_line_replay.sv */
`include "conv_params.svh"

module conv_line_replay (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  pixel_valid,
  input  conv_pkg::pixel_t      pixel_in,
  output logic                  beat_valid,
  output conv_pkg::replay_beat_t beat
);

  localparam conv_pkg::ic_idx_t IC_LAST = conv_pkg::ic_idx_t'(`CONV_CH_IN - 1);
  localparam conv_pkg::oc_idx_t OC_LAST = conv_pkg::oc_idx_t'(`CONV_CH_OUT - 1);

  conv_pkg::replay_state_t state;
  conv_pkg::ic_idx_t       ic;
  conv_pkg::oc_idx_t       oc;
  conv_pkg::pixel_t        line_buf [`CONV_CH_IN];

  ////////////////////////////////////////////////////////////
  // Fill and replay control
  ////////////////////////////////////////////////////////////
  // ic doubles as the fill pointer while collecting a group
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= conv_pkg::RP_FILL;
      ic    <= '0;
      oc    <= '0;
    end else if (state == conv_pkg::RP_FILL) begin
      if (pixel_valid) begin
        ic <= (ic == IC_LAST) ? '0 : ic + 1'b1;
        if (ic == IC_LAST) begin
          state <= conv_pkg::RP_PLAY;
          oc    <= '0;
        end
      end
    end else begin
      ic <= (ic == IC_LAST) ? '0 : ic + 1'b1;
      if (ic == IC_LAST) begin
        oc <= (oc == OC_LAST) ? '0 : oc + 1'b1;
        // Last beat of the group
        if (oc == OC_LAST) state <= conv_pkg::RP_FILL;
      end
    end
  end

  // Group storage
  always_ff @(posedge clk) begin
    if (state == conv_pkg::RP_FILL && pixel_valid) line_buf[ic] <= pixel_in;
  end

  ////////////////////////////////////////////////////////////
  // Beat output
  ////////////////////////////////////////////////////////////
  assign beat_valid = (state == conv_pkg::RP_PLAY);

  always_comb begin
    beat.data = line_buf[ic];
    beat.ic   = ic;
    beat.oc   = oc;
    if (ic == '0) beat.op = conv_pkg::MAC_FIRST;
    else if (ic == IC_LAST) beat.op = conv_pkg::MAC_LAST;
    else beat.op = conv_pkg::MAC_ACC;
  end

endmodule

/* conv1x1/conv_weight_store.sv */
`include "conv_params.svh"

module conv_weight_store (
  input  logic              clk,
  input  logic              reset,
  input  logic              weight_valid,
  input  conv_pkg::weight_t weight_in,
  input  conv_pkg::ic_idx_t rd_ic,
  input  conv_pkg::oc_idx_t rd_oc,
  output conv_pkg::weight_t rd_weight
);

  localparam int TABLE_N = `CONV_CH_IN * `CONV_CH_OUT;
  localparam int ADDR_W  = $clog2(TABLE_N);

  localparam logic [ADDR_W-1:0] ADDR_LAST = ADDR_W'(TABLE_N - 1);

  conv_pkg::weight_t weight_mem [TABLE_N];
  logic [ADDR_W-1:0] wr_ptr;
  logic [ADDR_W-1:0] rd_addr;

  ////////////////////////////////////////////////////////////
  // Sequential load
  ////////////////////////////////////////////////////////////
  // Entries arrive oc-major, so the pointer walks the table linearly
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
    end else if (weight_valid) begin
      wr_ptr <= (wr_ptr == ADDR_LAST) ? '0 : wr_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (weight_valid) weight_mem[wr_ptr] <= weight_in;
  end

  ////////////////////////////////////////////////////////////
  // Beat-addressed read
  ////////////////////////////////////////////////////////////
  // Same layout as the load order: oc * CH_IN + ic
  assign rd_addr = ADDR_W'(rd_oc) * ADDR_W'(`CONV_CH_IN) + ADDR_W'(rd_ic);

  assign rd_weight = weight_mem[rd_addr];

endmodule

/* conv1x1/conv_mac.sv */
`include "conv_params.svh"

module conv_mac (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   beat_valid,
  input  conv_pkg::replay_beat_t beat,
  input  conv_pkg::weight_t      weight,
  output logic                   sum_valid,
  output conv_pkg::out_t         sum
);

  // Signed output range, held at accumulator width
  localparam conv_pkg::acc_t OUT_MAX = conv_pkg::acc_t'(2 ** (`CONV_OUT_W - 1) - 1);
  localparam conv_pkg::acc_t OUT_MIN = conv_pkg::acc_t'(-(2 ** (`CONV_OUT_W - 1)));

  logic signed [2*`CONV_DATA_W-1:0] prod;
  conv_pkg::acc_t                   acc;
  conv_pkg::acc_t                   acc_base;
  conv_pkg::acc_t                   acc_next;
  conv_pkg::out_t                   sum_sat;

  ////////////////////////////////////////////////////////////
  // Product and running sum
  ////////////////////////////////////////////////////////////
  always_comb begin
    prod     = beat.data * weight;
    // A new output channel starts from zero
    acc_base = (beat.op == conv_pkg::MAC_FIRST) ? '0 : acc;
    acc_next = acc_base + conv_pkg::acc_t'(prod);
  end

  // Clamp to the output word
  always_comb begin
    if (acc_next > OUT_MAX) sum_sat = conv_pkg::out_t'(OUT_MAX);
    else if (acc_next < OUT_MIN) sum_sat = conv_pkg::out_t'(OUT_MIN);
    else sum_sat = conv_pkg::out_t'(acc_next);
  end

  always_ff @(posedge clk) begin
    if (beat_valid) acc <= acc_next;
  end

  ////////////////////////////////////////////////////////////
  // Result register
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      sum_valid <= 1'b0;
    end else begin
      sum_valid <= beat_valid && (beat.op == conv_pkg::MAC_LAST);
    end
  end

  always_ff @(posedge clk) begin
    if (beat_valid && beat.op == conv_pkg::MAC_LAST) sum <= sum_sat;
  end

endmodule

/* hw/conv_out_align.sv */
`include "conv_params.svh"

module conv_out_align (
  input  logic           clk,
  input  logic           reset,
  input  logic           sum_valid,
  input  conv_pkg::out_t sum,
  output conv_pkg::out_t pixel_out,
  output logic           valid_out
);

  localparam int PTR_W = $clog2(`CONV_FIFO_DEPTH);
  localparam int CNT_W = $clog2(`CONV_FIFO_DEPTH + 1);

  conv_pkg::out_t   fifo_mem [`CONV_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             started;
  logic             full;
  logic             empty;
  logic             wr_en;
  logic             rd_en;

  assign full  = (count == CNT_W'(`CONV_FIFO_DEPTH));
  assign empty = (count == '0);
  // A write into a full buffer is dropped
  assign wr_en = sum_valid && !full;
  assign rd_en = started && !empty;

  ////////////////////////////////////////////////////////////
  // Circular buffer
  ////////////////////////////////////////////////////////////
  // Depth is a power of two, pointers wrap on their own
  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      count   <= '0;
      started <= 1'b0;
    end else begin
      if (wr_en) wr_ptr <= wr_ptr + 1'b1;
      if (rd_en) rd_ptr <= rd_ptr + 1'b1;
      count <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
      // Sticky until reset
      if (count == CNT_W'(`CONV_OUT_START)) started <= 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (wr_en) fifo_mem[wr_ptr] <= sum;
  end

  ////////////////////////////////////////////////////////////
  // Registered output
  ////////////////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) valid_out <= 1'b0;
    else valid_out <= rd_en;
  end

  always_ff @(posedge clk) begin
    if (rd_en) pixel_out <= fifo_mem[rd_ptr];
  end

endmodule

/* hw/conv_1x1_layer.sv */
module conv_1x1_layer (
  input  logic              clk,
  input  logic              reset,
  input  logic              weight_valid,
  input  conv_pkg::weight_t weight_in,
  input  logic              pixel_valid,
  input  conv_pkg::pixel_t  pixel_in,
  output conv_pkg::out_t    pixel_out,
  output logic              valid_out
);

  // Replay beats feed both the weight read and the MAC
  logic                   beat_valid;
  conv_pkg::replay_beat_t beat;
  conv_pkg::weight_t      beat_weight;
  logic                   sum_valid;
  conv_pkg::out_t         sum;

  conv_line_replay u_line_replay (
    .clk        (clk),
    .reset      (reset),
    .pixel_valid(pixel_valid),
    .pixel_in   (pixel_in),
    .beat_valid (beat_valid),
    .beat       (beat)
  );

  // Configuration block next to the MAC it drives
  conv_weight_store u_weight_store (
    .clk         (clk),
    .reset       (reset),
    .weight_valid(weight_valid),
    .weight_in   (weight_in),
    .rd_ic       (beat.ic),
    .rd_oc       (beat.oc),
    .rd_weight   (beat_weight)
  );

  conv_mac u_mac (
    .clk       (clk),
    .reset     (reset),
    .beat_valid(beat_valid),
    .beat      (beat),
    .weight    (beat_weight),
    .sum_valid (sum_valid),
    .sum       (sum)
  );

  conv_out_align u_out_align (
    .clk      (clk),
    .reset    (reset),
    .sum_valid(sum_valid),
    .sum      (sum),
    .pixel_out(pixel_out),
    .valid_out(valid_out)
  );

endmodule

/* verif/conv_1x1_chk.sv */
`include "conv_params.svh"

module conv_1x1_chk (
  input logic                    clk,
  input logic                    reset,
  input logic                    pixel_valid,
  input logic                    valid_out,
  input logic                    sum_valid,
  input logic                    fifo_full,
  input conv_pkg::replay_state_t replay_state,
  input logic                    beat_valid,
  input conv_pkg::mac_op_t       beat_op
);
  timeunit 1ns;
  timeprecision 1ps;

  // Beats seen since the last MAC_FIRST
  int op_cnt;

  always_ff @(posedge clk) begin
    if (reset) begin
      op_cnt <= 0;
    end else if (beat_valid) begin
      op_cnt <= (beat_op == conv_pkg::MAC_FIRST) ? 1 : op_cnt + 1;
    end
  end

  a_fifo_no_overflow : assert property (@(posedge clk) disable iff (reset)
    !(sum_valid && fifo_full))
    else $error("Output FIFO written while full");

  // Source gap rule replaces back-pressure
  a_no_pixel_in_play : assert property (@(posedge clk) disable iff (reset)
    !(pixel_valid && replay_state == conv_pkg::RP_PLAY))
    else $error("Pixel arrived while the replay was playing a group");

  a_valid_low_after_reset : assert property (@(posedge clk)
    reset |=> !valid_out)
    else $error("valid_out high in the cycle after reset");

  // A run is MAC_FIRST and CH_IN-1 further ops ending in MAC_LAST
  a_op_sequence : assert property (@(posedge clk) disable iff (reset)
    beat_valid |->
      ((beat_op == conv_pkg::MAC_FIRST) ?
         (op_cnt == 0 || op_cnt == `CONV_CH_IN) :
         (op_cnt >= 1 && op_cnt <= `CONV_CH_IN - 1 &&
          ((beat_op == conv_pkg::MAC_LAST) == (op_cnt == `CONV_CH_IN - 1)))))
    else $error("Replay op sequence broken at op count %0d", op_cnt);

endmodule

bind conv_1x1_layer conv_1x1_chk u_chk (
  .clk         (clk),
  .reset       (reset),
  .pixel_valid (pixel_valid),
  .valid_out   (valid_out),
  .sum_valid   (sum_valid),
  .fifo_full   (u_out_align.full),
  .replay_state(u_line_replay.state),
  .beat_valid  (beat_valid),
  .beat_op     (beat.op)
);

/* verif/conv_1x1_tb.sv */
`include "conv_params.svh"

module conv_1x1_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int TABLE_N = `CONV_CH_IN * `CONV_CH_OUT;
  localparam int HOLD_CYCLES = 40;
  localparam int GROUP_CYCLES = `CONV_CH_IN * 3 + TABLE_N + 4;
  localparam int N_GROUPS = 43;
  localparam int N_LOADS = 6;
  localparam int LIMIT = 2 * (N_LOADS * TABLE_N + N_GROUPS * GROUP_CYCLES
                              + 2 * HOLD_CYCLES + 10 * `CONV_FIFO_DEPTH);

  logic              clk = 1'b0;
  logic              reset;
  logic              weight_valid;
  conv_pkg::weight_t weight_in;
  logic              pixel_valid;
  conv_pkg::pixel_t  pixel_in;
  conv_pkg::out_t    pixel_out;
  logic              valid_out;

  int             seed = 53;
  int             w_model [`CONV_CH_OUT][`CONV_CH_IN];
  int             px_cur [`CONV_CH_IN];
  conv_pkg::out_t exp_q [$];
  conv_pkg::out_t exp_val;
  string          test_name = "reset";
  int             errors = 0;
  int             out_count = 0;
  int             cycles = 0;
  int             test_err0;
  int             test_out0;

  conv_1x1_layer u_conv_1x1_layer (
    .clk         (clk),
    .reset       (reset),
    .weight_valid(weight_valid),
    .weight_in   (weight_in),
    .pixel_valid (pixel_valid),
    .pixel_in    (pixel_in),
    .pixel_out   (pixel_out),
    .valid_out   (valid_out)
  );

  always #5 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("Run hit the %0d cycle limit in test %s", LIMIT, test_name);
      $display("*** FAILED ***");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // Output monitor sampled at the falling edge
  ////////////////////////////////////////////////////////////
  always @(negedge clk) begin
    if (!reset && valid_out) begin
      out_count++;
      if (exp_q.size() == 0) begin
        errors++;
        $display("Test %s gave result %0d with none pending", test_name, pixel_out);
      end else begin
        exp_val = exp_q.pop_front();
        if (pixel_out !== exp_val) begin
          errors++;
          $display("Error test %s: expected %0d actual %0d", test_name, exp_val, pixel_out);
        end
      end
    end
  end

  function automatic conv_pkg::out_t clamp_out(input int value);
    int hi;
    int lo;
    hi = (1 << (`CONV_OUT_W - 1)) - 1;
    lo = -(1 << (`CONV_OUT_W - 1));
    if (value > hi) value = hi;
    else if (value < lo) value = lo;
    return conv_pkg::out_t'(value);
  endfunction

  // Oc-major table of random values or one constant
  task automatic load_weights(input bit use_rand, input int value);
    for (int oc = 0; oc < `CONV_CH_OUT; oc++) begin
      for (int ic = 0; ic < `CONV_CH_IN; ic++) begin
        w_model[oc][ic] = use_rand ? int'(conv_pkg::weight_t'($random(seed))) : value;
        @(posedge clk);
        #1;
        weight_valid = 1'b1;
        weight_in = conv_pkg::weight_t'(w_model[oc][ic]);
      end
    end
    @(posedge clk);
    #1;
    weight_valid = 1'b0;
  endtask

  task automatic send_group(input bit use_rand, input int value, input int tail);
    int gap;
    int acc;
    for (int ic = 0; ic < `CONV_CH_IN; ic++) begin
      px_cur[ic] = use_rand ? int'(conv_pkg::pixel_t'($random(seed))) : value;
    end
    for (int oc = 0; oc < `CONV_CH_OUT; oc++) begin
      acc = 0;
      for (int ic = 0; ic < `CONV_CH_IN; ic++) acc += px_cur[ic] * w_model[oc][ic];
      exp_q.push_back(clamp_out(acc));
    end
    for (int ic = 0; ic < `CONV_CH_IN; ic++) begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        @(posedge clk);
        #1;
        pixel_valid = 1'b0;
      end
      @(posedge clk);
      #1;
      pixel_valid = 1'b1;
      pixel_in = conv_pkg::pixel_t'(px_cur[ic]);
    end
    @(posedge clk);
    #1;
    pixel_valid = 1'b0;
    repeat (tail) @(posedge clk);
  endtask

  task automatic apply_reset();
    @(posedge clk);
    #1;
    reset = 1'b1;
    pixel_valid = 1'b0;
    weight_valid = 1'b0;
    exp_q.delete();
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;
  endtask

  task automatic start_test(input string name);
    test_name = name;
    test_err0 = errors;
    test_out0 = out_count;
  endtask

  // No result may leave the FIFO since the test began
  task automatic hold_check();
    repeat (HOLD_CYCLES) @(posedge clk);
    if (out_count != test_out0) begin
      errors++;
      $display("Test %s: valid_out rose before the FIFO start level", test_name);
    end
  endtask

  task automatic finish_test(input int exp_results);
    while (exp_q.size() != 0) @(posedge clk);
    repeat (4) @(posedge clk);
    if (out_count - test_out0 != exp_results) begin
      errors++;
      $display("Error test %s: expected %0d results actual %0d", test_name, exp_results,
               out_count - test_out0);
    end
    $display("Test %s done: %0d results, %0d errors", test_name, out_count - test_out0,
             errors - test_err0);
  endtask

  ////////////////////////////////////////////////////////////
  // Test sequence
  ////////////////////////////////////////////////////////////
  initial begin
    reset = 1'b1;
    weight_valid = 1'b0;
    weight_in = '0;
    pixel_valid = 1'b0;
    pixel_in = '0;
    repeat (4) @(posedge clk);
    #1;
    reset = 1'b0;

    start_test("threshold_hold");
    load_weights(1'b1, 0);
    send_group(1'b1, 0, TABLE_N + 4);
    hold_check();
    send_group(1'b1, 0, TABLE_N + 4);
    finish_test(2 * `CONV_CH_OUT);

    start_test("random_stream");
    repeat (30) send_group(1'b1, 0, TABLE_N + 4);
    finish_test(30 * `CONV_CH_OUT);

    start_test("saturation");
    load_weights(1'b0, 127);
    send_group(1'b0, 127, TABLE_N + 4);
    send_group(1'b0, -128, TABLE_N + 4);
    load_weights(1'b0, -128);
    send_group(1'b0, 127, TABLE_N + 4);
    send_group(1'b0, -128, TABLE_N + 4);
    finish_test(4 * `CONV_CH_OUT);

    start_test("weight_reload");
    load_weights(1'b1, 0);
    repeat (2) send_group(1'b1, 0, TABLE_N + 4);
    load_weights(1'b1, 0);
    repeat (2) send_group(1'b1, 0, TABLE_N + 4);
    finish_test(4 * `CONV_CH_OUT);

    // Reset lands while the replay is still playing
    send_group(1'b1, 0, 6);
    apply_reset();
    start_test("mid_run_reset");
    load_weights(1'b1, 0);
    send_group(1'b1, 0, TABLE_N + 4);
    hold_check();
    send_group(1'b1, 0, TABLE_N + 4);
    finish_test(2 * `CONV_CH_OUT);

    $display("Summary: 5 tests, %0d results checked, %0d errors", out_count, errors);
    if (errors == 0) begin
      $display("*** PASSED ***");
    end else begin
      $display("*** FAILED ***");
    end
    $finish;
  end

endmodule

/* compile.f */
+incdir+common
common/conv_pkg.sv
conv1x1/conv_line_replay.sv
conv1x1/conv_weight_store.sv
conv1x1/conv_mac.sv
hw/conv_out_align.sv
hw/conv_1x1_layer.sv
verif/conv_1x1_chk.sv
verif/conv_1x1_tb.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f compile.f --top-module conv_1x1_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/Vconv_1x1_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q -F '*** FAILED ***' "$LOG"; then
  echo "Simulation reported failure"
  exit 1
fi

echo "Simulation completed without failure"
exit 0
